//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module ex_pipeline_tb -f vlog.f \
    && ./obj_dir/Vex_pipeline_tb | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- verification/ex_pipeline_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module ex_pipeline_tb;

    import lc3b_types::*;

    localparam int NUM_VECTORS = 400;
    // vectors plus reset, drain and a quarter of margin.
    localparam int MAX_CYCLES = NUM_VECTORS + NUM_VECTORS / 4;

    typedef struct packed {
        lc3b_word         npc_in;
        lc3b_control_word cw_in;
        lc3b_word         ir_in;
        lc3b_word         sr1;
        lc3b_word         sr2;
        lc3b_nzp          cc_in;
        lc3b_reg          dr_in;
        lc3b_reg          sr1_reg_in;
        lc3b_reg          sr2_reg_in;
        logic             valid_in;
        lc3b_opcode       next_opcode;
        lc3b_reg          mem_dr;
        logic             wb_ld_cc;
        logic             mem_stall;
        logic             mem_br_stall;
        logic             icache_stall;
    } stage_inputs;

    typedef struct packed {
        lc3b_word         address;
        lc3b_control_word cw;
        lc3b_word         npc;
        lc3b_nzp          cc;
        lc3b_word         result;
        lc3b_word         ir;
        lc3b_reg          dr;
        logic             valid;
        logic             load_mem;
        logic             ex_load_cc;
        logic             ex_load_regfile;
        logic             execute_br_stall;
        logic             execute_indirect_stall;
        logic             leapfrog_load;
        logic             leapfrog_stall;
    } stage_outputs;

    logic             clk;
    logic             rst;
    stage_inputs      stim;
    stage_outputs     expected;
    stage_outputs     held;
    logic             data_known;
    integer           seed = 6;
    int               error_count = 0;
    int               check_count = 0;
    int               cycles;
    event             applied;

    lc3b_word         mem_address;
    lc3b_control_word mem_cw;
    lc3b_word         mem_npc;
    lc3b_nzp          mem_cc;
    lc3b_word         mem_result;
    lc3b_word         mem_ir;
    lc3b_reg          mem_dr_out;
    logic             mem_valid;
    logic             ex_load_cc;
    logic             ex_load_regfile;
    logic             execute_br_stall;
    logic             execute_indirect_stall;
    logic             leapfrog_load;
    logic             leapfrog_stall;

    ex_pipeline UUT
    (
        .clk(clk),
        .rst(rst),
        .npc_in(stim.npc_in),
        .cw_in(stim.cw_in),
        .ir_in(stim.ir_in),
        .sr1(stim.sr1),
        .sr2(stim.sr2),
        .cc_in(stim.cc_in),
        .dr_in(stim.dr_in),
        .sr1_reg_in(stim.sr1_reg_in),
        .sr2_reg_in(stim.sr2_reg_in),
        .valid_in(stim.valid_in),
        .next_opcode(stim.next_opcode),
        .mem_dr(stim.mem_dr),
        .wb_ld_cc(stim.wb_ld_cc),
        .mem_stall(stim.mem_stall),
        .mem_br_stall(stim.mem_br_stall),
        .icache_stall(stim.icache_stall),
        .mem_address(mem_address),
        .mem_cw(mem_cw),
        .mem_npc(mem_npc),
        .mem_cc(mem_cc),
        .mem_result(mem_result),
        .mem_ir(mem_ir),
        .mem_dr_out(mem_dr_out),
        .mem_valid(mem_valid),
        .ex_load_cc(ex_load_cc),
        .ex_load_regfile(ex_load_regfile),
        .execute_br_stall(execute_br_stall),
        .execute_indirect_stall(execute_indirect_stall),
        .leapfrog_load(leapfrog_load),
        .leapfrog_stall(leapfrog_stall)
    );

    initial clk = 1'b0;

    always #5 clk = ~clk;

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic logic roll(input int percent);
        return pick(100) < percent;
    endfunction

    // second memory trip of LDI or STI.
    function automatic lc3b_control_word indirect_cw(input logic is_load);
        lc3b_control_word w;
        w = '0;
        w.opcode = is_load ? op_ldr : op_str;
        w.aluop = alu_pass;
        w.load_cc = is_load;
        w.load_regfile = is_load;
        w.mem_read = is_load;
        w.mem_write = !is_load;
        w.sr1_needed = 1'b1;
        w.addr1mux_sel = 1'b1;
        w.addr2mux_sel = 2'd1;
        return w;
    endfunction

    function automatic stage_outputs predict_stage(input stage_inputs s);
        stage_outputs p;
        lc3b_word     b;
        lc3b_word     base;
        lc3b_word     offset;
        logic         hazard;
        p = '0;
        p.npc = s.npc_in;
        p.cc = s.cc_in;
        p.ir = s.ir_in;
        p.dr = s.dr_in;

        case (s.cw_in.sr2mux_sel)
            2'd1: b = {{(`LC3B_WORD_WIDTH-5){s.ir_in[4]}}, s.ir_in[4:0]};
            2'd2: b = {{(`LC3B_WORD_WIDTH-4){1'b0}}, s.ir_in[3:0]};
            default: b = s.sr2;
        endcase
        case (s.cw_in.aluop)
            alu_add: p.result = s.sr1 + b;
            alu_and: p.result = s.sr1 & b;
            alu_not: p.result = ~s.sr1;
            alu_sll: p.result = s.sr1 << b[3:0];
            alu_srl: p.result = s.sr1 >> b[3:0];
            alu_sra: p.result = lc3b_word'($signed(s.sr1) >>> b[3:0]);
            default: p.result = s.sr1;
        endcase

        // offsets are the low 6, 9 or 11 bits of the instruction.
        base = s.cw_in.addr1mux_sel ? s.sr1 : s.npc_in;
        case (s.cw_in.addr2mux_sel)
            2'd1: offset = {{(`LC3B_WORD_WIDTH-6){s.ir_in[5]}}, s.ir_in[5:0]};
            2'd2: offset = {{(`LC3B_WORD_WIDTH-9){s.ir_in[8]}}, s.ir_in[8:0]};
            2'd3: offset = {{(`LC3B_WORD_WIDTH-11){s.ir_in[10]}}, s.ir_in[10:0]};
            default: offset = '0;
        endcase
        if (s.cw_in.lshf_enable)
            offset = offset << 1;
        if (s.cw_in.memaddrmux_sel)
            p.address = {{(`LC3B_WORD_WIDTH-9){1'b0}}, s.ir_in[7:0], 1'b0};
        else
            p.address = base + offset;

        p.cw = s.cw_in;
        p.execute_indirect_stall = (s.next_opcode == op_ldi) || (s.next_opcode == op_sti);
        if (p.execute_indirect_stall)
            p.cw = indirect_cw(s.next_opcode == op_ldi);

        p.ex_load_cc = s.valid_in && s.cw_in.load_cc;
        p.ex_load_regfile = s.valid_in && s.cw_in.load_regfile;
        p.execute_br_stall = s.valid_in && s.cw_in.branch_stall;

        hazard = (s.cw_in.sr1_needed && (s.sr1_reg_in == s.mem_dr)) ||
                 (s.cw_in.sr2_needed && (s.sr2_reg_in == s.mem_dr)) ||
                 s.cw_in.mem_read || s.cw_in.mem_write ||
                 ((s.cw_in.opcode == op_br) && s.wb_ld_cc);
        p.leapfrog_load = s.mem_stall && s.valid_in && !hazard;
        p.leapfrog_stall = s.mem_stall && s.valid_in && hazard;

        p.load_mem = !(s.mem_stall || s.icache_stall);
        p.valid = s.valid_in && !s.mem_br_stall && !p.leapfrog_stall;
        return p;
    endfunction

    task automatic build_cw(input lc3b_opcode op, output lc3b_control_word cw);
        cw = '0;
        cw.opcode = op;
        cw.aluop = alu_pass;
        case (op)
            op_add, op_and:
            begin
                cw.aluop = (op == op_add) ? alu_add : alu_and;
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr1_needed = 1'b1;
                cw.sr2mux_sel = roll(50) ? 2'd1 : 2'd0;
                cw.sr2_needed = (cw.sr2mux_sel == 2'd0);
            end
            op_not, op_shf:
            begin
                cw.load_cc = 1'b1;
                cw.load_regfile = 1'b1;
                cw.sr1_needed = 1'b1;
                cw.aluop = alu_not;
                if (op == op_shf)
                begin
                    cw.sr2mux_sel = 2'd2;
                    case (pick(3))
                        0: cw.aluop = alu_sll;
                        1: cw.aluop = alu_srl;
                        default: cw.aluop = alu_sra;
                    endcase
                end
            end
            op_br, op_jsr, op_lea:
            begin
                cw.branch_stall = (op != op_lea);
                cw.load_regfile = (op != op_br);
                cw.load_cc = (op == op_lea);
                cw.addr2mux_sel = (op == op_jsr) ? 2'd3 : 2'd2;
                cw.lshf_enable = 1'b1;
            end
            op_jmp:
            begin
                cw.branch_stall = 1'b1;
                cw.sr1_needed = 1'b1;
                cw.addr1mux_sel = 1'b1;
            end
            op_ldr, op_ldi, op_ldb, op_str, op_sti, op_stb:
            begin
                cw.mem_read = (op == op_ldr) || (op == op_ldi) || (op == op_ldb);
                cw.mem_write = !cw.mem_read;
                cw.load_cc = cw.mem_read;
                cw.load_regfile = cw.mem_read;
                cw.sr1_needed = 1'b1;
                cw.sr2_needed = cw.mem_write;
                cw.addr1mux_sel = 1'b1;
                cw.addr2mux_sel = 2'd1;
                // byte accesses keep the offset unscaled.
                cw.lshf_enable = (op != op_ldb) && (op != op_stb);
            end
            op_trap:
            begin
                cw.branch_stall = 1'b1;
                cw.load_regfile = 1'b1;
                cw.memaddrmux_sel = 1'b1;
            end
            default:
            begin
                cw.aluop = alu_pass;
            end
        endcase
    endtask

    task automatic random_stimulus(output stage_inputs s);
        lc3b_opcode op;
        lc3b_word   raw;
        op = lc3b_opcode'(pick(16));
        raw = lc3b_word'($random(seed));
        build_cw(op, s.cw_in);
        s.ir_in = {op, raw[11:0]};
        s.npc_in = lc3b_word'($random(seed));
        s.sr1 = lc3b_word'($random(seed));
        s.sr2 = lc3b_word'($random(seed));
        s.cc_in = lc3b_nzp'(pick(8));
        s.dr_in = lc3b_reg'(pick(8));
        s.sr1_reg_in = lc3b_reg'(pick(8));
        s.sr2_reg_in = lc3b_reg'(pick(8));
        s.mem_dr = lc3b_reg'(pick(8));
        s.valid_in = roll(85);
        s.next_opcode = lc3b_opcode'(pick(16));
        s.wb_ld_cc = roll(50);
        s.mem_stall = roll(25);
        s.mem_br_stall = roll(15);
        s.icache_stall = roll(15);
    endtask

    task automatic apply_stimulus(input stage_inputs s);
        stim = s;
        expected = predict_stage(s);
        -> applied;
    endtask

    task automatic check_word(input string name, input lc3b_word got, input lc3b_word exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_cw(input lc3b_control_word got, input lc3b_control_word exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t: mem_cw is %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_nzp(input lc3b_nzp got, input lc3b_nzp exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t: mem_cc is %b, expected %b", $time, got, exp);
        end
    endtask

    task automatic check_reg(input lc3b_reg got, input lc3b_reg exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("error at %0t: mem_dr_out is %0d, expected %0d", $time, got, exp);
        end
    endtask

    // stimulus and end of run.
    initial
    begin
        stage_inputs vec;
        rst = 1'b1;
        stim = '0;
        expected = predict_stage(stim);
        // live traffic during reset, so only the reset can clear the control side.
        for (int i = 0; i < 3; i++)
        begin
            @(negedge clk);
            random_stimulus(vec);
            apply_stimulus(vec);
        end
        rst = 1'b0;
        for (int n = 0; n < NUM_VECTORS; n++)
        begin
            @(negedge clk);
            random_stimulus(vec);
            apply_stimulus(vec);
        end
        @(negedge clk);
        apply_stimulus('0);
        @(negedge clk);
        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    // combinational outputs are compared before the edge and the latch after it.
    initial
    begin
        held = '0;
        data_known = 1'b0;
        forever
        begin
            @(applied);
            #4;
            check_bit("ex_load_cc", ex_load_cc, expected.ex_load_cc);
            check_bit("ex_load_regfile", ex_load_regfile, expected.ex_load_regfile);
            check_bit("execute_br_stall", execute_br_stall, expected.execute_br_stall);
            check_bit("execute_indirect_stall", execute_indirect_stall,
                      expected.execute_indirect_stall);
            check_bit("leapfrog_load", leapfrog_load, expected.leapfrog_load);
            check_bit("leapfrog_stall", leapfrog_stall, expected.leapfrog_stall);
            @(posedge clk);
            if (expected.load_mem)
            begin
                held = expected;
                data_known = 1'b1;
            end
            if (rst)
            begin
                held.valid = 1'b0;
                held.cw = '0;
            end
            #1;
            check_bit("mem_valid", mem_valid, held.valid);
            check_cw(mem_cw, held.cw);
            // data fields carry no reset value.
            if (data_known)
            begin
                check_word("mem_address", mem_address, held.address);
                check_word("mem_npc", mem_npc, held.npc);
                check_word("mem_result", mem_result, held.result);
                check_word("mem_ir", mem_ir, held.ir);
                check_nzp(mem_cc, held.cc);
                check_reg(mem_dr_out, held.dr);
            end
        end
    end

    initial
    begin
        cycles = 0;
        while (cycles < MAX_CYCLES)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule : ex_pipeline_tb

`default_nettype wire

//--- verilog/addr_gen.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module addr_gen
(
    input  logic                  addr1mux_sel,
    input  logic [1:0]            addr2mux_sel,
    input  logic                  lshf_enable,
    input  logic                  memaddrmux_sel,
    input  lc3b_types::lc3b_word  npc,
    input  lc3b_types::lc3b_word  base,
    input  lc3b_types::lc3b_instr instr,
    output lc3b_types::lc3b_word  address
);

    import lc3b_types::*;

    logic [8:0]  off9;
    logic [10:0] off11;
    logic [7:0]  trapvect8;
    lc3b_word    addr1;
    lc3b_word    offset;
    lc3b_word    shifted;
    lc3b_word    trap_addr;

    // the wider offsets reach up into the base and dr slots.
    assign off9      = {instr.mem.base, instr.mem.offset6};
    assign off11     = {instr.mem.dr[1:0], instr.mem.base, instr.mem.offset6};
    assign trapvect8 = {instr.mem.base[1:0], instr.mem.offset6};

    assign addr1 = addr1mux_sel ? base : npc;

    always_comb
    begin
        case (addr2mux_sel)
            2'b01:
            begin
                offset = {{(`LC3B_WORD_WIDTH-6){instr.mem.offset6[5]}}, instr.mem.offset6};
            end
            2'b10:
            begin
                offset = {{(`LC3B_WORD_WIDTH-9){off9[8]}}, off9};
            end
            2'b11:
            begin
                offset = {{(`LC3B_WORD_WIDTH-11){off11[10]}}, off11};
            end
            default:
            begin
                offset = '0;
            end
        endcase
    end

    // word accesses and branches scale the offset to bytes.
    assign shifted = lshf_enable ? {offset[`LC3B_WORD_WIDTH-2:0], 1'b0} : offset;

    assign trap_addr = {{(`LC3B_WORD_WIDTH-9){1'b0}}, trapvect8, 1'b0};

    assign address = memaddrmux_sel ? trap_addr : addr1 + shifted;

endmodule : addr_gen

`default_nettype wire

//--- verilog/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "lc3b_consts.svh"

module alu
(
    input  lc3b_types::lc3b_aluop aluop,
    input  logic [1:0]            sr2mux_sel,
    input  lc3b_types::lc3b_word  a,
    input  lc3b_types::lc3b_word  b_reg,
    input  lc3b_types::lc3b_instr instr,
    output lc3b_types::lc3b_word  f
);

    import lc3b_types::*;

    lc3b_word                     b;
    logic [`LC3B_SHAMT_WIDTH-1:0] shamt;

    assign shamt = b[`LC3B_SHAMT_WIDTH-1:0];

    // second operand.
    always_comb
    begin
        case (sr2mux_sel)
            2'b01: b = {{(`LC3B_WORD_WIDTH-5){instr.op.imm5[4]}}, instr.op.imm5};
            2'b10: b = {{(`LC3B_WORD_WIDTH-`LC3B_SHAMT_WIDTH){1'b0}},
                        instr.op.imm5[`LC3B_SHAMT_WIDTH-1:0]};
            default: b = b_reg;
        endcase
    end

    always_comb
    begin
        case (aluop)
            alu_add: f = a + b;
            alu_and: f = a & b;
            alu_not: f = ~a;
            alu_sll: f = a << shamt;
            alu_srl: f = a >> shamt;
            alu_sra: f = $signed(a) >>> shamt;
            default: f = a;
        endcase
    end

    // decode never emits the fourth operand code.
    always_comb
    begin
        assert final (sr2mux_sel != 2'b11)
            else $error("alu: unused sr2mux_sel code %b", sr2mux_sel);
    end

endmodule : alu

`default_nettype wire

//--- verilog/ex_mem_latch.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_latch
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         load,

    input  lc3b_types::lc3b_word         address,
    input  lc3b_types::lc3b_control_word cw,
    input  lc3b_types::lc3b_word         npc,
    input  lc3b_types::lc3b_nzp          cc,
    input  lc3b_types::lc3b_word         result,
    input  lc3b_types::lc3b_word         ir,
    input  lc3b_types::lc3b_reg          dr,
    input  logic                         valid,

    output lc3b_types::lc3b_word         mem_address,
    output lc3b_types::lc3b_control_word mem_cw,
    output lc3b_types::lc3b_word         mem_npc,
    output lc3b_types::lc3b_nzp          mem_cc,
    output lc3b_types::lc3b_word         mem_result,
    output lc3b_types::lc3b_word         mem_ir,
    output lc3b_types::lc3b_reg          mem_dr_out,
    output logic                         mem_valid
);

    // control side.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mem_valid <= 1'b0;
            mem_cw    <= '0;
        end
        else if (load)
        begin
            mem_valid <= valid;
            mem_cw    <= cw;
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            mem_address <= address;
            mem_npc     <= npc;
            mem_cc      <= cc;
            mem_result  <= result;
            mem_ir      <= ir;
            mem_dr_out  <= dr;
        end
    end

    assert property (@(posedge clk) rst |=> !mem_valid)
        else $error("ex_mem_latch: valid set right after reset");

endmodule : ex_mem_latch

`default_nettype wire

//--- verilog/ex_pipeline.sv
`timescale 1ns/10ps
`default_nettype none

module ex_pipeline
(
    input  logic                         clk,
    input  logic                         rst,

    input  lc3b_types::lc3b_word         npc_in,
    input  lc3b_types::lc3b_control_word cw_in,
    input  lc3b_types::lc3b_word         ir_in,
    input  lc3b_types::lc3b_word         sr1,
    input  lc3b_types::lc3b_word         sr2,
    input  lc3b_types::lc3b_nzp          cc_in,
    input  lc3b_types::lc3b_reg          dr_in,
    input  lc3b_types::lc3b_reg          sr1_reg_in,
    input  lc3b_types::lc3b_reg          sr2_reg_in,
    input  logic                         valid_in,
    input  lc3b_types::lc3b_opcode       next_opcode,
    input  lc3b_types::lc3b_reg          mem_dr,
    input  logic                         wb_ld_cc,
    input  logic                         mem_stall,
    input  logic                         mem_br_stall,
    input  logic                         icache_stall,

    output lc3b_types::lc3b_word         mem_address,
    output lc3b_types::lc3b_control_word mem_cw,
    output lc3b_types::lc3b_word         mem_npc,
    output lc3b_types::lc3b_nzp          mem_cc,
    output lc3b_types::lc3b_word         mem_result,
    output lc3b_types::lc3b_word         mem_ir,
    output lc3b_types::lc3b_reg          mem_dr_out,
    output logic                         mem_valid,
    output logic                         ex_load_cc,
    output logic                         ex_load_regfile,
    output logic                         execute_br_stall,
    output logic                         execute_indirect_stall,
    output logic                         leapfrog_load,
    output logic                         leapfrog_stall
);

    import lc3b_types::*;

    lc3b_word         ex_address;
    lc3b_control_word ex_cw;
    lc3b_word         ex_npc;
    lc3b_nzp          ex_cc;
    lc3b_word         ex_result;
    lc3b_word         ex_ir;
    lc3b_reg          ex_dr;
    logic             ex_valid;
    logic             load_mem;

    execute execute_i
    (
        .clk(clk),
        .npc_in(npc_in),
        .cw_in(cw_in),
        .ir_in(ir_in),
        .sr1(sr1),
        .sr2(sr2),
        .cc_in(cc_in),
        .dr_in(dr_in),
        .sr1_reg_in(sr1_reg_in),
        .sr2_reg_in(sr2_reg_in),
        .valid_in(valid_in),
        .next_opcode(next_opcode),
        .mem_dr(mem_dr),
        .wb_ld_cc(wb_ld_cc),
        .mem_stall(mem_stall),
        .mem_br_stall(mem_br_stall),
        .icache_stall(icache_stall),
        .address(ex_address),
        .cw(ex_cw),
        .npc(ex_npc),
        .cc(ex_cc),
        .result(ex_result),
        .ir(ex_ir),
        .dr(ex_dr),
        .valid(ex_valid),
        .load_mem(load_mem),
        .ex_load_cc(ex_load_cc),
        .ex_load_regfile(ex_load_regfile),
        .execute_br_stall(execute_br_stall),
        .execute_indirect_stall(execute_indirect_stall),
        .leapfrog_load(leapfrog_load),
        .leapfrog_stall(leapfrog_stall)
    );

    ex_mem_latch ex_mem_latch_i
    (
        .clk(clk),
        .rst(rst),
        .load(load_mem),
        .address(ex_address),
        .cw(ex_cw),
        .npc(ex_npc),
        .cc(ex_cc),
        .result(ex_result),
        .ir(ex_ir),
        .dr(ex_dr),
        .valid(ex_valid),
        .mem_address(mem_address),
        .mem_cw(mem_cw),
        .mem_npc(mem_npc),
        .mem_cc(mem_cc),
        .mem_result(mem_result),
        .mem_ir(mem_ir),
        .mem_dr_out(mem_dr_out),
        .mem_valid(mem_valid)
    );

endmodule : ex_pipeline

`default_nettype wire

//--- verilog/ex_stall_logic.sv
`timescale 1ns/10ps
`default_nettype none

module ex_stall_logic
(
    input  logic valid_in,
    input  logic mem_stall,
    input  logic mem_br_stall,
    input  logic icache_stall,
    input  logic leapfrog_stall,
    output logic valid,
    output logic load_mem
);

    logic back_pressure;
    logic squash;

    // the latch holds while memory or the icache is busy.
    assign back_pressure = mem_stall || icache_stall;
    assign load_mem = !back_pressure;

    // a branch resolving in memory flushes this slot.
    assign squash = mem_br_stall || leapfrog_stall;
    assign valid = valid_in && !squash;

endmodule : ex_stall_logic

`default_nettype wire

//--- verilog/execute.sv
`timescale 1ns/10ps
`default_nettype none

module execute
(
    input  logic                         clk,

    input  lc3b_types::lc3b_word         npc_in,
    input  lc3b_types::lc3b_control_word cw_in,
    input  lc3b_types::lc3b_word         ir_in,
    input  lc3b_types::lc3b_word         sr1,
    input  lc3b_types::lc3b_word         sr2,
    input  lc3b_types::lc3b_nzp          cc_in,
    input  lc3b_types::lc3b_reg          dr_in,
    input  lc3b_types::lc3b_reg          sr1_reg_in,
    input  lc3b_types::lc3b_reg          sr2_reg_in,
    input  logic                         valid_in,
    input  lc3b_types::lc3b_opcode       next_opcode,
    input  lc3b_types::lc3b_reg          mem_dr,
    input  logic                         wb_ld_cc,
    input  logic                         mem_stall,
    input  logic                         mem_br_stall,
    input  logic                         icache_stall,

    output lc3b_types::lc3b_word         address,
    output lc3b_types::lc3b_control_word cw,
    output lc3b_types::lc3b_word         npc,
    output lc3b_types::lc3b_nzp          cc,
    output lc3b_types::lc3b_word         result,
    output lc3b_types::lc3b_word         ir,
    output lc3b_types::lc3b_reg          dr,
    output logic                         valid,
    output logic                         load_mem,
    output logic                         ex_load_cc,
    output logic                         ex_load_regfile,
    output logic                         execute_br_stall,
    output logic                         execute_indirect_stall,
    output logic                         leapfrog_load,
    output logic                         leapfrog_stall
);

    import lc3b_types::*;

    lc3b_instr        instr;
    lc3b_control_word ldr_cw;
    lc3b_control_word str_cw;

    assign instr = ir_in;

    assign npc = npc_in;
    assign cc  = cc_in;
    assign ir  = ir_in;
    assign dr  = dr_in;

    // second trip of an indirect access, base plus off6.
    always_comb
    begin
        ldr_cw = '0;
        ldr_cw.opcode = op_ldr;
        ldr_cw.aluop = alu_pass;
        ldr_cw.load_cc = 1'b1;
        ldr_cw.load_regfile = 1'b1;
        ldr_cw.mem_read = 1'b1;
        ldr_cw.addr1mux_sel = 1'b1;
        ldr_cw.addr2mux_sel = 2'b01;
        ldr_cw.sr1_needed = 1'b1;

        str_cw = '0;
        str_cw.opcode = op_str;
        str_cw.aluop = alu_pass;
        str_cw.mem_write = 1'b1;
        str_cw.addr1mux_sel = 1'b1;
        str_cw.addr2mux_sel = 2'b01;
        str_cw.sr1_needed = 1'b1;
    end

    always_comb
    begin
        execute_indirect_stall = 1'b0;
        cw = cw_in;
        if (next_opcode == op_ldi)
        begin
            execute_indirect_stall = 1'b1;
            cw = ldr_cw;
        end
        else if (next_opcode == op_sti)
        begin
            execute_indirect_stall = 1'b1;
            cw = str_cw;
        end
    end

    assign ex_load_cc       = valid_in && cw_in.load_cc;
    assign ex_load_regfile  = valid_in && cw_in.load_regfile;
    assign execute_br_stall = valid_in && cw_in.branch_stall;

    alu alu_i
    (
        .aluop(cw_in.aluop),
        .sr2mux_sel(cw_in.sr2mux_sel),
        .a(sr1),
        .b_reg(sr2),
        .instr(instr),
        .f(result)
    );

    addr_gen addr_gen_i
    (
        .addr1mux_sel(cw_in.addr1mux_sel),
        .addr2mux_sel(cw_in.addr2mux_sel),
        .lshf_enable(cw_in.lshf_enable),
        .memaddrmux_sel(cw_in.memaddrmux_sel),
        .npc(npc_in),
        .base(sr1),
        .instr(instr),
        .address(address)
    );

    leapfrog_logic leapfrog_logic_i
    (
        .mem_stall(mem_stall),
        .valid_in(valid_in),
        .cw(cw_in),
        .sr1_reg(sr1_reg_in),
        .sr2_reg(sr2_reg_in),
        .mem_dr(mem_dr),
        .wb_ld_cc(wb_ld_cc),
        .leapfrog_load(leapfrog_load),
        .leapfrog_stall(leapfrog_stall)
    );

    ex_stall_logic ex_stall_logic_i
    (
        .valid_in(valid_in),
        .mem_stall(mem_stall),
        .mem_br_stall(mem_br_stall),
        .icache_stall(icache_stall),
        .leapfrog_stall(leapfrog_stall),
        .valid(valid),
        .load_mem(load_mem)
    );

    // the rewritten word must send the indirect pointer back to memory.
    assert property (@(posedge clk) execute_indirect_stall |-> (cw.mem_read || cw.mem_write))
        else $error("execute: indirect rewrite without a memory access");

endmodule : execute

`default_nettype wire

//--- verilog/lc3b_consts.svh
`ifndef LC3B_CONSTS_SVH
`define LC3B_CONSTS_SVH

// data and address word of the datapath.
`define LC3B_WORD_WIDTH 16

// register file index.
`define LC3B_REG_WIDTH 3

// shift amount held in the low bits of an operate instruction.
`define LC3B_SHAMT_WIDTH 4

`endif

//--- verilog/lc3b_types.sv
`default_nettype none

`include "lc3b_consts.svh"

package lc3b_types;

    typedef logic [`LC3B_WORD_WIDTH-1:0] lc3b_word;
    typedef logic [`LC3B_REG_WIDTH-1:0] lc3b_reg;
    typedef logic [2:0] lc3b_nzp;

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_aluop  aluop;
        logic       load_cc;
        logic       load_regfile;
        logic       branch_stall;
        logic       mem_read;
        logic       mem_write;
        logic       sr1_needed;
        logic       sr2_needed;
        logic       lshf_enable;
        logic [1:0] sr2mux_sel;     // register, imm5 or imm4.
        logic       addr1mux_sel;   // npc or sr1.
        logic [1:0] addr2mux_sel;   // zero, off6, off9 or off11.
        logic       memaddrmux_sel; // adder or trap vector.
    } lc3b_control_word;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    sr1;
        logic       imm;
        logic [4:0] imm5;
    } lc3b_operate_fmt;

    typedef struct packed {
        lc3b_opcode opcode;
        lc3b_reg    dr;
        lc3b_reg    base;
        logic [5:0] offset6;
    } lc3b_memory_fmt;

    typedef union packed {
        lc3b_operate_fmt op;
        lc3b_memory_fmt  mem;
    } lc3b_instr;

endpackage : lc3b_types

`default_nettype wire

//--- verilog/leapfrog_logic.sv
`timescale 1ns/10ps
`default_nettype none

module leapfrog_logic
(
    input  logic                         mem_stall,
    input  logic                         valid_in,
    input  lc3b_types::lc3b_control_word cw,
    input  lc3b_types::lc3b_reg          sr1_reg,
    input  lc3b_types::lc3b_reg          sr2_reg,
    input  lc3b_types::lc3b_reg          mem_dr,
    input  logic                         wb_ld_cc,
    output logic                         leapfrog_load,
    output logic                         leapfrog_stall
);

    import lc3b_types::*;

    logic src_conflict;
    logic uses_memory;
    logic cc_hazard;

    assign src_conflict = (cw.sr1_needed && (sr1_reg == mem_dr)) ||
                          (cw.sr2_needed && (sr2_reg == mem_dr));

    assign uses_memory = cw.mem_read || cw.mem_write;

    // a branch has to see the codes writeback is about to set.
    assign cc_hazard = (cw.opcode == op_br) && wb_ld_cc;

    assign leapfrog_load = mem_stall && valid_in && !uses_memory &&
                           !src_conflict && !cc_hazard;

    assign leapfrog_stall = mem_stall && valid_in && !leapfrog_load;

    always_comb
    begin
        assert final (!(leapfrog_load && leapfrog_stall))
            else $error("leapfrog_logic: load and stall raised together");
    end

endmodule : leapfrog_logic

`default_nettype wire

//--- vlog.f
+incdir+verilog
verilog/lc3b_types.sv
verilog/alu.sv
verilog/addr_gen.sv
verilog/leapfrog_logic.sv
verilog/ex_stall_logic.sv
verilog/execute.sv
verilog/ex_mem_latch.sv
verilog/ex_pipeline.sv
verification/ex_pipeline_tb.sv
